// File: hdl/trellis_pkg.sv
`default_nettype none

package trellis_pkg;

    ////////////////////////////////////////
    // widths and types
    ////////////////////////////////////////

    // 8-state constituent code
    localparam int NUM_STATES = 8;

    localparam int LLR_W    = 16;
    localparam int METRIC_W = 16;
    localparam int BLKLEN_W = 16;

    // soft input value
    typedef logic signed [LLR_W-1:0] llr_t;

    // state or branch metric that wraps on overflow
    typedef logic signed [METRIC_W-1:0] metric_t;

    // all state metrics with state 0 in bits [15:0]
    typedef logic [NUM_STATES*METRIC_W-1:0] metric_vec_t;

    // block length in symbols
    typedef logic [BLKLEN_W-1:0] blklen_t;

    ////////////////////////////////////////
    // trellis wiring
    ////////////////////////////////////////

    // predecessor taking +branch
    localparam int PRED_A [NUM_STATES] = '{0, 4, 5, 1, 2, 6, 7, 3};

    // predecessor taking -branch
    localparam int PRED_B [NUM_STATES] = '{4, 0, 1, 5, 6, 2, 3, 7};

    // bit s set means state s uses branch2
    // states 2 to 5 see the parity-subtracted metric
    localparam logic [NUM_STATES-1:0] USE_BRANCH2 = 8'b0011_1100;

    ////////////////////////////////////////
    // start values and timing
    ////////////////////////////////////////

    // encoder starts in state 0
    localparam metric_t METRIC_START_ZERO  = 16'sd0;
    localparam metric_t METRIC_START_OTHER = -16'sd128;

    // accepted symbol to metrics_o in clock cycles
    // branch reg then acs reg then output reg
    localparam int PIPE_LAT = 3;

    ////////////////////////////////////////
    // block controller states
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/branch_metric.sv
`timescale 1ns/100ps
`default_nettype none

module branch_metric import trellis_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    sym_accept_i,
    input  llr_t    sys_i,
    input  llr_t    parity_i,
    input  llr_t    apriori_i,
    output metric_t branch1_o,
    output metric_t branch2_o,
    output logic    branch_valid_o
);

    // systematic plus a-priori is shared by both branches
    metric_t sum_sa;
    // parity added
    metric_t sum_pos;
    // parity subtracted
    metric_t sum_neg;

    ////////////////////////////////////////
    // combinational sums
    ////////////////////////////////////////

    // plain 16 bit wrap
    assign sum_sa  = sys_i + apriori_i;
    assign sum_pos = sum_sa + parity_i;
    assign sum_neg = sum_sa - parity_i;

    ////////////////////////////////////////
    // output registers
    ////////////////////////////////////////

    // metrics only move on an accepted symbol
    always_ff @(posedge clk) begin
        if (sym_accept_i) begin
            // halve with sign kept
            branch1_o <= sum_pos >>> 1;
            branch2_o <= sum_neg >>> 1;
        end
    end

    // one strobe per accepted symbol
    always_ff @(posedge clk) begin
        if (rst) begin
            branch_valid_o <= 1'b0;
        end else begin
            branch_valid_o <= sym_accept_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/acs_unit.sv
`timescale 1ns/100ps
`default_nettype none

module acs_unit import trellis_pkg::*; #(
    parameter metric_t START_METRIC = METRIC_START_OTHER
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    init_i,
    input  logic    step_i,
    input  metric_t metric_a_i,
    input  metric_t metric_b_i,
    input  metric_t branch_i,
    output metric_t metric_o
);

    // path through pred A adds the branch
    metric_t cand_a;
    // path through pred B subtracts it
    metric_t cand_b;

    assign cand_a = metric_a_i + branch_i;
    assign cand_b = metric_b_i - branch_i;

    ////////////////////////////////////////
    // state metric register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || init_i) begin
            // block start value
            metric_o <= START_METRIC;
        end else if (step_i) begin
            // signed compare then select survivor
            if (cand_a > cand_b) begin
                metric_o <= cand_a;
            end else begin
                metric_o <= cand_b;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/metric_normalizer.sv
`timescale 1ns/100ps
`default_nettype none

module metric_normalizer import trellis_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  metric_vec_t raw_i,
    input  logic        step_done_i,
    output metric_vec_t norm_o,
    output metric_vec_t metrics_o,
    output logic        metrics_valid_o
);

    // raw state 0 is the reference for every state
    metric_t ref_metric;

    assign ref_metric = raw_i[METRIC_W-1:0];

    ////////////////////////////////////////
    // feedback path
    ////////////////////////////////////////

    // combinational so the acs units see it on the next step
    // state 0 always comes out as zero
    always_comb begin
        for (int s = 0; s < NUM_STATES; s++) begin
            norm_o[s*METRIC_W +: METRIC_W] = metric_t'(raw_i[s*METRIC_W +: METRIC_W] - ref_metric);
        end
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    // capture once per trellis step
    always_ff @(posedge clk) begin
        if (step_done_i) begin
            metrics_o <= norm_o;
        end
    end

    // one cycle strobe with each new vector
    always_ff @(posedge clk) begin
        if (rst) begin
            metrics_valid_o <= 1'b0;
        end else begin
            metrics_valid_o <= step_done_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/block_controller.sv
`timescale 1ns/100ps
`default_nettype none

module block_controller import trellis_pkg::*; #(
    parameter int BLK_W = 16
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    start_i,
    input  logic    valid_i,
    input  blklen_t blklen_i,
    output logic    sym_accept_o,
    output logic    init_o,
    output logic    busy_o,
    output logic    done_o
);

    // enough bits to count PIPE_LAT drain cycles
    localparam int DRAIN_W = $clog2(PIPE_LAT + 1);

    ctrl_state_t          state_q;
    ctrl_state_t          state_d;
    logic [BLK_W-1:0]     blklen_w;
    logic [BLK_W-1:0]     len_q;
    logic [BLK_W-1:0]     sym_cnt;
    logic [DRAIN_W-1:0]   drain_cnt;
    logic                 start_ok;
    logic                 last_sym;
    logic                 drain_last;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    // counter width may differ from the port width
    assign blklen_w = BLK_W'(blklen_i);

    // zero length and starts while busy are dropped
    assign start_ok     = start_i && (state_q == IDLE) && (blklen_w != '0);
    assign sym_accept_o = valid_i && (state_q == RUN);
    assign last_sym     = sym_accept_o && (sym_cnt == len_q - 1'b1);
    assign drain_last   = (drain_cnt == DRAIN_W'(PIPE_LAT - 1));

    // done lines up with the metrics of the last symbol
    assign done_o = (state_q == DRAIN) && drain_last;
    assign busy_o = (state_q != IDLE);

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_ok) state_d = RUN;
            RUN:     if (last_sym) state_d = DRAIN;
            DRAIN:   if (drain_last) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            sym_cnt   <= '0;
            drain_cnt <= '0;
            init_o    <= 1'b0;
        end else begin
            state_q <= state_d;
            // one cycle pulse resets the acs units
            init_o  <= start_ok;
            // counts accepted symbols of this block
            if (state_q != RUN) begin
                sym_cnt <= '0;
            end else if (sym_accept_o) begin
                sym_cnt <= sym_cnt + 1'b1;
            end
            // cycles spent waiting for the pipeline
            if (state_q != DRAIN) begin
                drain_cnt <= '0;
            end else begin
                drain_cnt <= drain_cnt + 1'b1;
            end
        end
    end

    // block length held for the whole block
    always_ff @(posedge clk) begin
        if (start_ok) begin
            len_q <= blklen_w;
        end
    end

endmodule

`default_nettype wire

// File: hdl/forward_metric_top.sv
`timescale 1ns/100ps
`default_nettype none

module forward_metric_top import trellis_pkg::*; #(
    parameter int BLK_W = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  blklen_t     blklen_i,
    input  logic        valid_i,
    input  llr_t        sys_i,
    input  llr_t        parity_i,
    input  llr_t        apriori_i,
    output metric_vec_t metrics_o,
    output logic        metrics_valid_o,
    output logic        busy_o,
    output logic        done_o
);

    logic        sym_accept;
    logic        init_pulse;
    metric_t     branch1;
    metric_t     branch2;
    logic        branch_valid;
    // high in the cycle after an acs step
    logic        step_done;
    metric_vec_t raw_vec;
    metric_vec_t norm_vec;

    ////////////////////////////////////////
    // block framing
    ////////////////////////////////////////

    block_controller #(
        .BLK_W (BLK_W)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_i),
        .valid_i      (valid_i),
        .blklen_i     (blklen_i),
        .sym_accept_o (sym_accept),
        .init_o       (init_pulse),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    // gamma for both branch classes
    branch_metric u_branch (
        .clk            (clk),
        .rst            (rst),
        .sym_accept_i   (sym_accept),
        .sys_i          (sys_i),
        .parity_i       (parity_i),
        .apriori_i      (apriori_i),
        .branch1_o      (branch1),
        .branch2_o      (branch2),
        .branch_valid_o (branch_valid)
    );

    ////////////////////////////////////////
    // acs array
    ////////////////////////////////////////

    // predecessors come from the normalized feedback
    for (genvar s = 0; s < NUM_STATES; s++) begin : g_state
        metric_t branch_sel;

        assign branch_sel = USE_BRANCH2[s] ? branch2 : branch1;

        acs_unit #(
            .START_METRIC ((s == 0) ? METRIC_START_ZERO : METRIC_START_OTHER)
        ) u_acs (
            .clk        (clk),
            .rst        (rst),
            .init_i     (init_pulse),
            .step_i     (branch_valid),
            .metric_a_i (norm_vec[PRED_A[s]*METRIC_W +: METRIC_W]),
            .metric_b_i (norm_vec[PRED_B[s]*METRIC_W +: METRIC_W]),
            .branch_i   (branch_sel),
            .metric_o   (raw_vec[s*METRIC_W +: METRIC_W])
        );
    end

    // acs registers have updated when this is high
    always_ff @(posedge clk) begin
        if (rst) begin
            step_done <= 1'b0;
        end else begin
            step_done <= branch_valid;
        end
    end

    ////////////////////////////////////////
    // normalization and output
    ////////////////////////////////////////

    metric_normalizer u_norm (
        .clk             (clk),
        .rst             (rst),
        .raw_i           (raw_vec),
        .step_done_i     (step_done),
        .norm_o          (norm_vec),
        .metrics_o       (metrics_o),
        .metrics_valid_o (metrics_valid_o)
    );

endmodule

`default_nettype wire

// File: sim/forward_metric_chk.sv
`timescale 1ns/100ps
`default_nettype none

module forward_metric_chk import trellis_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  metric_vec_t metrics_o,
    input  logic        metrics_valid_o,
    input  logic        busy_o,
    input  logic        done_o
);

    // number of assertion failures so far
    int fail_count = 0;

    ////////////////////////////////////////
    // output protocol
    ////////////////////////////////////////

    // done marks the last vector of a block
    a_done_valid : assert property (@(posedge clk) disable iff (rst) done_o |-> metrics_valid_o)
        else begin
            $error("done_o high without metrics_valid_o");
            fail_count++;
        end

    // vectors only inside a block
    a_valid_busy : assert property (@(posedge clk) disable iff (rst) metrics_valid_o |-> busy_o)
        else begin
            $error("metrics_valid_o high while not busy");
            fail_count++;
        end

    // normalization leaves state 0 at zero
    a_state0_zero : assert property (@(posedge clk) disable iff (rst)
        metrics_valid_o |-> (metrics_o[METRIC_W-1:0] == '0))
        else begin
            $error("state 0 metric not zero");
            fail_count++;
        end

endmodule

bind forward_metric_top forward_metric_chk u_chk (
    .clk             (clk),
    .rst             (rst),
    .metrics_o       (metrics_o),
    .metrics_valid_o (metrics_valid_o),
    .busy_o          (busy_o),
    .done_o          (done_o)
);

`default_nettype wire

// File: sim/forward_metric_tb.sv
`timescale 1ns/100ps
`default_nettype none

module forward_metric_tb
    import trellis_pkg::*;
();

    localparam int NUM_BLOCKS = 12;
    localparam int MAX_LEN    = 40;
    // accepting edge to the edge that samples the vector
    localparam int OUT_LAT    = 3;
    localparam int WAIT_LIMIT = 20;

    logic        clk = 1'b0;
    logic        rst;
    logic        start_i;
    blklen_t     blklen_i;
    logic        valid_i;
    llr_t        sys_i;
    llr_t        parity_i;
    llr_t        apriori_i;
    metric_vec_t metrics_o;
    logic        metrics_valid_o;
    logic        busy_o;
    logic        done_o;

    integer seed = 32'h8c54_06f0;
    int     cyc;
    int     value_errs;
    int     proto_errs;
    int     timeouts;
    int     out_count;
    int     done_count;
    // reference busy level
    logic   exp_busy;

    // expected vectors with their output edge and done flag
    metric_vec_t exp_vec_q [$];
    int          exp_cyc_q [$];
    logic        exp_last_q [$];

    // normalized metrics after the latest model step
    metric_t model_norm [NUM_STATES];

    forward_metric_top #(
        .BLK_W (16)
    ) dut (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start_i),
        .blklen_i        (blklen_i),
        .valid_i         (valid_i),
        .sys_i           (sys_i),
        .parity_i        (parity_i),
        .apriori_i       (apriori_i),
        .metrics_o       (metrics_o),
        .metrics_valid_o (metrics_valid_o),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    // 4 ns period
    initial begin
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_metrics(input string name, input metric_vec_t got, input metric_vec_t want);
        if (got !== want) begin
            $display("ERROR %s got %h expected %h", name, got, want);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERROR %s got %h expected %h", name, got, want);
            value_errs++;
        end
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // soft value in -100..100
    function automatic llr_t rand_soft();
        return llr_t'($random(seed) % 101);
    endfunction

    task automatic set_soft();
        sys_i     = rand_soft();
        parity_i  = rand_soft();
        apriori_i = rand_soft();
    endtask

    // state 0 known at block start
    task automatic model_reset();
        for (int s = 0; s < NUM_STATES; s++) begin
            model_norm[s] = (s == 0) ? METRIC_START_ZERO : METRIC_START_OTHER;
        end
    endtask

    // one trellis step in wrapping 16 bit arithmetic
    function automatic metric_vec_t model_step(input llr_t sys, input llr_t par, input llr_t apr);
        metric_t     sa;
        metric_t     tmp;
        metric_t     br1;
        metric_t     br2;
        metric_t     br;
        metric_t     ca;
        metric_t     cb;
        metric_t     raw [NUM_STATES];
        metric_vec_t vec;
        sa  = sys + apr;
        tmp = sa + par;
        br1 = tmp >>> 1;
        tmp = sa - par;
        br2 = tmp >>> 1;
        for (int s = 0; s < NUM_STATES; s++) begin
            br = USE_BRANCH2[s] ? br2 : br1;
            ca = model_norm[PRED_A[s]] + br;
            cb = model_norm[PRED_B[s]] - br;
            raw[s] = (ca > cb) ? ca : cb;
        end
        // everything relative to state 0
        for (int s = 0; s < NUM_STATES; s++) begin
            model_norm[s] = raw[s] - raw[0];
            vec[s*METRIC_W +: METRIC_W] = model_norm[s];
        end
        return vec;
    endfunction

    ////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////

    // samples before the edge updates anything
    always @(posedge clk) begin : monitor
        metric_vec_t want_vec;
        int          want_cyc;
        logic        want_last;
        want_last = 1'b0;
        cyc = cyc + 1;
        if (rst) begin
            exp_busy = 1'b0;
        end else begin
            check_bit("busy_o", busy_o, exp_busy);
            if (metrics_valid_o) begin
                out_count++;
                if (exp_vec_q.size() == 0) begin
                    $display("output vector at cycle %0d with none expected", cyc);
                    proto_errs++;
                end else begin
                    want_vec  = exp_vec_q.pop_front();
                    want_cyc  = exp_cyc_q.pop_front();
                    want_last = exp_last_q.pop_front();
                    check_metrics("metrics_o", metrics_o, want_vec);
                    check_bit("done_o", done_o, want_last);
                    if (want_cyc != cyc) begin
                        $display("vector arrived at cycle %0d instead of %0d", cyc, want_cyc);
                        proto_errs++;
                    end
                end
            end else begin
                check_bit("done_o", done_o, 1'b0);
            end
            if (done_o) begin
                done_count++;
            end
            // busy for the next edge
            if (start_i && !exp_busy && blklen_i != '0) begin
                exp_busy = 1'b1;
            end else if (want_last) begin
                exp_busy = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic run_block(input int len, input bit zero_try, output bit ok);
        int base_out;
        int gap;
        int waited;
        ok = 1'b1;
        base_out = out_count;
        // symbol while idle and maybe a zero length start
        set_soft();
        valid_i = 1'b1;
        start_i = zero_try;
        blklen_i = '0;
        @(negedge clk);
        valid_i = 1'b0;
        start_i = 1'b1;
        blklen_i = blklen_t'(len);
        @(negedge clk);
        start_i = 1'b0;
        waited = 0;
        while (!busy_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!busy_o) begin
            $display("busy_o never rose after a start of length %0d", len);
            timeouts++;
            ok = 1'b0;
            return;
        end
        model_reset();
        for (int sent = 0; sent < len; sent++) begin
            // mostly back to back with some gaps up to 4
            gap = $random(seed) & 7;
            gap = (gap < 4) ? 0 : gap - 3;
            repeat (gap) begin
                valid_i = 1'b0;
                // a start here lands while busy
                start_i = 1'($random(seed));
                blklen_i = blklen_t'($random(seed));
                @(negedge clk);
            end
            start_i = 1'b0;
            set_soft();
            valid_i = 1'b1;
            exp_vec_q.push_back(model_step(sys_i, parity_i, apriori_i));
            exp_cyc_q.push_back(cyc + 1 + OUT_LAT);
            exp_last_q.push_back(sent == len - 1);
            @(negedge clk);
        end
        // two stray symbols during drain and a start with the first
        set_soft();
        start_i = 1'b1;
        blklen_i = blklen_t'(len);
        @(negedge clk);
        start_i = 1'b0;
        set_soft();
        @(negedge clk);
        valid_i = 1'b0;
        waited = 0;
        while (busy_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (busy_o) begin
            $display("busy_o stayed high after a block of length %0d", len);
            timeouts++;
            ok = 1'b0;
            return;
        end
        if (exp_vec_q.size() != 0 || out_count - base_out != len) begin
            $display("block of length %0d gave %0d vectors", len, out_count - base_out);
            proto_errs++;
        end
    endtask

    initial begin : stimulus
        int len;
        bit ok;
        rst       = 1'b1;
        start_i   = 1'b0;
        blklen_i  = '0;
        valid_i   = 1'b0;
        sys_i     = '0;
        parity_i  = '0;
        apriori_i = '0;
        cyc        = 0;
        value_errs = 0;
        proto_errs = 0;
        timeouts   = 0;
        out_count  = 0;
        done_count = 0;
        exp_busy   = 1'b0;
        ok         = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // quiet period after reset
        repeat (3) @(negedge clk);
        for (int blk = 0; blk < NUM_BLOCKS && ok; blk++) begin
            len = 1 + (($random(seed) & 32'h7fff_ffff) % MAX_LEN);
            run_block(len, (blk % 4) == 1, ok);
        end
        if (ok && done_count != NUM_BLOCKS) begin
            $display("saw %0d done pulses over %0d blocks", done_count, NUM_BLOCKS);
            proto_errs++;
        end
        $display("value errors %0d, protocol errors %0d, timeouts %0d, assertion failures %0d",
                 value_errs, proto_errs, timeouts, dut.u_chk.fail_count);
        if (value_errs + proto_errs + timeouts + dut.u_chk.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/trellis_pkg.sv
hdl/branch_metric.sv
hdl/acs_unit.sv
hdl/metric_normalizer.sv
hdl/block_controller.sv
hdl/forward_metric_top.sv
sim/forward_metric_chk.sv
sim/forward_metric_tb.sv
